// File: fetch_params.svh
// fixed RV32 fetch constants; queue sizing assumes two parcels per memory word and <= 3 words in flight
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

////////////////////////////////////////
// reset and queue sizing

// first fetch address after reset
`define FETCH_PC_INIT 32'h0000_0200

// parcel queue depth, in 16-bit parcels
`define FETCH_QUEUE_DEPTH 12

// stop requesting at this fill level
// room left for two words in flight plus the one being acked
`define FETCH_FULL_THRESHOLD 6

////////////////////////////////////////
// instruction constants

`define FETCH_NOP 32'h0000_0013   // addi x0,x0,0
`define FETCH_WFI 32'h1050_0073   // wfi, executed as nop

`endif

// File: fetch_pkg.sv
// RV32 only; rvc_op_e covers the compressed subset kept, everything else decodes as C_OTHER
`include "fetch_params.svh"

package fetch_pkg;

  typedef logic [15:0] parcel_t;   // one halfword
  typedef logic [31:0] instr_t;    // one expanded instruction
  typedef logic [31:0] addr_t;

  // queue fill count, must reach the full depth
  typedef logic [$clog2(`FETCH_QUEUE_DEPTH+1)-1:0] level_t;

  // RV32 major opcodes used to build expanded instructions
  typedef enum logic [6:0] {
    LOAD   = 7'b000_0011,
    STORE  = 7'b010_0011,
    OP_IMM = 7'b001_0011,
    OP     = 7'b011_0011,
    LUI    = 7'b011_0111,
    BRANCH = 7'b110_0011,
    JAL    = 7'b110_1111,
    JALR   = 7'b110_0111,
    SYSTEM = 7'b111_0011
  } rv_opcode_e;

  // compressed opcodes, {jalr sel, funct3, quadrant}
  // bit 5 only splits C.JR/C.MV from C.JALR/C.ADD/C.EBREAK
  typedef enum logic [5:0] {
    C_ADDI4SPN = 6'b0_000_00,
    C_LW       = 6'b0_010_00,
    C_SW       = 6'b0_110_00,
    C_ADDI     = 6'b0_000_01,   // also C.NOP
    C_JAL      = 6'b0_001_01,
    C_LI       = 6'b0_010_01,
    C_LUI      = 6'b0_011_01,   // also C.ADDI16SP
    C_J        = 6'b0_101_01,
    C_BEQZ     = 6'b0_110_01,
    C_BNEZ     = 6'b0_111_01,
    C_SLLI     = 6'b0_000_10,
    C_LWSP     = 6'b0_010_10,
    C_JR       = 6'b0_100_10,   // also C.MV
    C_JALR     = 6'b1_100_10,   // also C.ADD, C.EBREAK
    C_SWSP     = 6'b0_110_10,
    C_OTHER    = 6'b1_111_11    // not a 16-bit key, never collides
  } rvc_op_e;

endpackage

// File: parcel_bus_if.sv
// queue head view for the expander; head_parcels[1] is only meaningful when level >= 2
`timescale 1ns/1ps

interface parcel_bus_if;

  fetch_pkg::parcel_t [1:0] head_parcels;   // [0] oldest
  fetch_pkg::level_t        level;          // parcels held
  logic               [1:0] head_fault;     // access error per head parcel
  logic               [1:0] rd_count;       // parcels popped at next edge, 0..2

  modport queue (
    output head_parcels,
    output level,
    output head_fault,
    input  rd_count
  );

  modport expander (
    input  head_parcels,
    input  level,
    input  head_fault,
    output rd_count
  );

endinterface

// File: fetch_addr_gen.sv
// linear fetch only; assumes the memory drops words in flight while imem_flush_o is high
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_addr_gen (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             imem_ack_i,
  input  logic             bu_flush_i,
  input  fetch_pkg::addr_t bu_nxt_pc_i,
  input  logic             almost_full_i,
  output fetch_pkg::addr_t imem_adr_o,
  output logic             imem_req_o,
  output logic             imem_flush_o
);

  logic accepted;

  // the redirect strobe flushes memory side and queue alike
  assign imem_flush_o = bu_flush_i;

  // no request while queue near full or during flush
  assign imem_req_o = ~almost_full_i & ~bu_flush_i;

  assign accepted = imem_req_o & imem_ack_i;

  ////////////////////////////////////////
  // address register
  //
  // a redirect target may sit on an odd halfword, bit 1 is kept
  // so the memory returns the upper parcel only; the next
  // address is word aligned again
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
      imem_adr_o <= `FETCH_PC_INIT;
    else if (bu_flush_i)
      imem_adr_o <= {bu_nxt_pc_i[31:1], 1'b0};                 // redirect wins
    else if (accepted)
      imem_adr_o <= {imem_adr_o[31:2] + 30'd1, 2'b00};          // next word
  end

endmodule

// File: parcel_queue.sv
// holds FETCH_QUEUE_DEPTH parcels; relies on almost-full early enough that writes never overflow
`timescale 1ns/1ps
`include "fetch_params.svh"

module parcel_queue (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  fetch_pkg::instr_t wr_parcels_i,   // [15:0] lower, [31:16] upper
  input  logic        [1:0] wr_valid_i,     // one bit per halfword
  input  logic              wr_error_i,     // access error for the whole word
  parcel_bus_if.queue       bus,
  output logic              almost_full_o
);

  localparam int DEPTH = `FETCH_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  typedef logic [PTR_W-1:0] ptr_t;

  // circular index add, depth need not be a power of two
  function automatic ptr_t wrap_add(ptr_t ptr, logic [1:0] n);
    logic [PTR_W:0] sum;
    sum = {1'b0, ptr} + (PTR_W+1)'(n);
    return (sum >= DEPTH) ? ptr_t'(sum - DEPTH) : ptr_t'(sum);
  endfunction

  fetch_pkg::parcel_t parcels [DEPTH];
  logic               faults  [DEPTH];   // access error per entry

  ptr_t              wr_ptr;
  ptr_t              rd_ptr;
  ptr_t              wr_idx_hi;   // slot for the upper halfword
  ptr_t              rd_nxt;      // second head entry
  fetch_pkg::level_t level;
  logic        [1:0] wr_count;

  assign wr_count  = {1'b0, wr_valid_i[0]} + {1'b0, wr_valid_i[1]};
  assign wr_idx_hi = wr_valid_i[0] ? wrap_add(wr_ptr, 2'd1) : wr_ptr;   // low first
  assign rd_nxt    = wrap_add(rd_ptr, 2'd1);

  ////////////////////////////////////////
  // storage, written low parcel first
  always_ff @(posedge clk_i)
  begin
    if (!flush_i)                                   // data in flush cycle is stale
    begin
      if (wr_valid_i[0])
      begin
        parcels[wr_ptr] <= wr_parcels_i[15:0];
        faults[wr_ptr]  <= wr_error_i;
      end
      if (wr_valid_i[1])
      begin
        parcels[wr_idx_hi] <= wr_parcels_i[31:16];
        faults[wr_idx_hi]  <= wr_error_i;
      end
    end
  end

  ////////////////////////////////////////
  // pointers and fill level
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end
    else if (flush_i)                               // empty on next edge
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end
    else
    begin
      wr_ptr <= wrap_add(wr_ptr, wr_count);
      rd_ptr <= wrap_add(rd_ptr, bus.rd_count);     // expander never over-reads
      level  <= level + fetch_pkg::level_t'(wr_count)
                      - fetch_pkg::level_t'(bus.rd_count);
    end
  end

  // two oldest parcels, valid up to level
  assign bus.head_parcels[0] = parcels[rd_ptr];
  assign bus.head_parcels[1] = parcels[rd_nxt];
  assign bus.head_fault      = {faults[rd_nxt], faults[rd_ptr]};
  assign bus.level           = level;

  assign almost_full_o = level >= fetch_pkg::level_t'(`FETCH_FULL_THRESHOLD);

endmodule

// File: rvc_expander.sv
// RV32C subset only; out-of-subset and reserved encodings leave as zero-extended illegal parcels
`timescale 1ns/1ps
`include "fetch_params.svh"

module rvc_expander (
  parcel_bus_if.expander    bus,
  input  logic              stall_i,
  output fetch_pkg::instr_t insn_o,
  output logic              valid_o,
  output logic              is_rvc_o,
  output logic              illegal_o,
  output logic              fault_o
);

  ////////////////////////////////////////
  // RV32 format encoders
  function automatic fetch_pkg::instr_t enc_i(fetch_pkg::rv_opcode_e op, logic [2:0] f3,
                                              logic [4:0] rd, logic [4:0] rs1,
                                              logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic fetch_pkg::instr_t enc_s(logic [4:0] rs1, logic [4:0] rs2,
                                              logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], fetch_pkg::STORE};   // sw only
  endfunction

  function automatic fetch_pkg::instr_t enc_b(logic [2:0] f3, logic [4:0] rs1,
                                              logic [12:0] imm);
    return {imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], fetch_pkg::BRANCH};
  endfunction

  function automatic fetch_pkg::instr_t enc_j(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, fetch_pkg::JAL};
  endfunction

  function automatic fetch_pkg::instr_t enc_u(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, fetch_pkg::LUI};
  endfunction

  function automatic fetch_pkg::instr_t enc_r(logic [4:0] rd, logic [4:0] rs1,
                                              logic [4:0] rs2);
    return {7'b000_0000, rs2, rs1, 3'b000, rd, fetch_pkg::OP};          // add only
  endfunction

  fetch_pkg::parcel_t  p;          // head parcel
  fetch_pkg::instr_t   word;       // head as 32-bit instruction
  fetch_pkg::instr_t   rvc_insn;
  fetch_pkg::rvc_op_e  op;
  logic          [5:0] key;
  logic                rvc_bad;
  logic          [4:0] rd, rs2;    // full register fields
  logic          [4:0] rp_hi;      // rs1'/rd' at [9:7]
  logic          [4:0] rp_lo;      // rd'/rs2' at [4:2]
  logic         [11:0] ci_imm;     // signed 6-bit CI immediate
  logic         [11:0] sp_imm;     // C.ADDI16SP
  logic         [11:0] lw_imm;     // C.LW / C.SW offset
  logic         [20:0] j_imm;
  logic         [12:0] b_imm;

  assign p    = bus.head_parcels[0];
  assign word = {bus.head_parcels[1], p};

  ////////////////////////////////////////
  // length decode and queue pop
  assign is_rvc_o = p[1:0] != 2'b11;
  assign valid_o  = is_rvc_o ? (bus.level != '0)
                             : (bus.level >= fetch_pkg::level_t'(2));
  assign bus.rd_count = (valid_o && !stall_i) ? (is_rvc_o ? 2'd1 : 2'd2) : 2'd0;

  // a 16-bit insn ignores the fault of the parcel after it
  assign fault_o = is_rvc_o ? bus.head_fault[0] : |bus.head_fault;

  // field extraction
  assign rd     = p[11:7];
  assign rs2    = p[6:2];
  assign rp_hi  = {2'b01, p[9:7]};
  assign rp_lo  = {2'b01, p[4:2]};
  assign ci_imm = {{7{p[12]}}, p[6:2]};
  assign sp_imm = {{3{p[12]}}, p[4:3], p[5], p[2], p[6], 4'b0000};
  assign lw_imm = {5'b00000, p[5], p[12:10], p[6], 2'b00};
  assign j_imm  = {{10{p[12]}}, p[8], p[10:9], p[6], p[7], p[2], p[11], p[5:3], 1'b0};
  assign b_imm  = {{5{p[12]}}, p[6:5], p[2], p[11:10], p[4:3], 1'b0};

  // opcode key, bit 5 only for the quadrant 2 funct3=100 group
  assign key = {(p[15:13] == 3'b100) && (p[1:0] == 2'b10) && p[12], p[15:13], p[1:0]};

  always_comb
    case (key)
      fetch_pkg::C_ADDI4SPN, fetch_pkg::C_LW,   fetch_pkg::C_SW,
      fetch_pkg::C_ADDI,     fetch_pkg::C_JAL,  fetch_pkg::C_LI,
      fetch_pkg::C_LUI,      fetch_pkg::C_J,    fetch_pkg::C_BEQZ,
      fetch_pkg::C_BNEZ,     fetch_pkg::C_SLLI, fetch_pkg::C_LWSP,
      fetch_pkg::C_JR,       fetch_pkg::C_JALR, fetch_pkg::C_SWSP:
        op = fetch_pkg::rvc_op_e'(key);
      default:
        op = fetch_pkg::C_OTHER;                   // C.SRLI..C.AND, FP, RV64
    endcase

  ////////////////////////////////////////
  // reserved encodings
  always_comb
    case (op)
      fetch_pkg::C_ADDI4SPN: rvc_bad = p[12:5] == 8'h00;            // incl. all-zero
      fetch_pkg::C_LUI:      rvc_bad = {p[12], p[6:2]} == 6'h00;    // nzimm
      fetch_pkg::C_SLLI:     rvc_bad = p[12];                       // shamt[5] on RV32
      fetch_pkg::C_LWSP:     rvc_bad = rd == 5'd0;
      fetch_pkg::C_JR:       rvc_bad = (rd == 5'd0) && (rs2 == 5'd0);
      fetch_pkg::C_OTHER:    rvc_bad = 1'b1;
      default:               rvc_bad = 1'b0;
    endcase

  ////////////////////////////////////////
  // expansion
  always_comb
    case (op)
      fetch_pkg::C_ADDI4SPN: rvc_insn = enc_i(fetch_pkg::OP_IMM, 3'b000, rp_lo, 5'd2,
                                              {2'b00, p[10:7], p[12:11], p[5], p[6], 2'b00});
      fetch_pkg::C_LW:       rvc_insn = enc_i(fetch_pkg::LOAD, 3'b010, rp_lo, rp_hi, lw_imm);
      fetch_pkg::C_SW:       rvc_insn = enc_s(rp_hi, rp_lo, lw_imm);
      fetch_pkg::C_ADDI:     rvc_insn = enc_i(fetch_pkg::OP_IMM, 3'b000, rd, rd, ci_imm);
      fetch_pkg::C_JAL:      rvc_insn = enc_j(5'd1, j_imm);          // link in x1
      fetch_pkg::C_LI:       rvc_insn = enc_i(fetch_pkg::OP_IMM, 3'b000, rd, 5'd0, ci_imm);
      fetch_pkg::C_LUI:      rvc_insn = (rd == 5'd2)
                                      ? enc_i(fetch_pkg::OP_IMM, 3'b000, 5'd2, 5'd2, sp_imm)
                                      : enc_u(rd, {{8{ci_imm[11]}}, ci_imm});
      fetch_pkg::C_J:        rvc_insn = enc_j(5'd0, j_imm);
      fetch_pkg::C_BEQZ:     rvc_insn = enc_b(3'b000, rp_hi, b_imm);
      fetch_pkg::C_BNEZ:     rvc_insn = enc_b(3'b001, rp_hi, b_imm);
      fetch_pkg::C_SLLI:     rvc_insn = enc_i(fetch_pkg::OP_IMM, 3'b001, rd, rd, {7'b0, rs2});
      fetch_pkg::C_LWSP:     rvc_insn = enc_i(fetch_pkg::LOAD, 3'b010, rd, 5'd2,
                                              {4'b0000, p[3:2], p[12], p[6:4], 2'b00});
      // C.MV or C.JR
      fetch_pkg::C_JR:       rvc_insn = (rs2 != 5'd0)
                                      ? enc_r(rd, 5'd0, rs2)
                                      : enc_i(fetch_pkg::JALR, 3'b000, 5'd0, rd, 12'h000);
      // C.ADD, C.JALR or C.EBREAK
      fetch_pkg::C_JALR:     rvc_insn = (rs2 != 5'd0) ? enc_r(rd, rd, rs2)
                                      : (rd != 5'd0)
                                      ? enc_i(fetch_pkg::JALR, 3'b000, 5'd1, rd, 12'h000)
                                      : enc_i(fetch_pkg::SYSTEM, 3'b000, 5'd0, 5'd0, 12'h001);
      fetch_pkg::C_SWSP:     rvc_insn = enc_s(5'd2, rs2, {4'b0000, p[8:7], p[12:9], 2'b00});
      default:               rvc_insn = {16'h0000, p};
    endcase

  assign illegal_o = is_rvc_o & rvc_bad;

  always_comb
    if (!is_rvc_o)
      insn_o = (word == `FETCH_WFI) ? `FETCH_NOP : word;   // wfi runs as nop
    else if (rvc_bad)
      insn_o = {16'h0000, p};                              // raw parcel for the trap
    else
      insn_o = rvc_insn;

endmodule

// File: fetch_out_stage.sv
// one register stage; a redirect kills the output even while decode stalls
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_out_stage (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              bu_flush_i,
  input  fetch_pkg::addr_t  bu_nxt_pc_i,
  input  logic              pd_stall_i,
  input  logic              valid_i,
  input  logic              is_rvc_i,
  input  logic              illegal_i,
  input  logic              fault_i,
  input  fetch_pkg::instr_t insn_i,
  output fetch_pkg::addr_t  if_pc_o,
  output fetch_pkg::instr_t if_insn_o,
  output logic              if_bubble_o,
  output logic              if_illegal_o,
  output logic              if_access_fault_o
);

  fetch_pkg::addr_t nxt_pc;   // pc of the queue head
  logic             consume;

  assign consume = valid_i & ~pd_stall_i;   // same condition as the queue pop

  ////////////////////////////////////////
  // program counters
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
      nxt_pc <= `FETCH_PC_INIT;
    else if (bu_flush_i)
      nxt_pc <= {bu_nxt_pc_i[31:1], 1'b0};
    else if (consume)
      nxt_pc <= nxt_pc + (is_rvc_i ? 32'd2 : 32'd4);
  end

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
      if_pc_o <= `FETCH_PC_INIT;
    else if (!pd_stall_i)
      if_pc_o <= nxt_pc;
  end

  ////////////////////////////////////////
  // instruction and flags
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      if_insn_o         <= `FETCH_NOP;
      if_bubble_o       <= 1'b1;
      if_illegal_o      <= 1'b0;
      if_access_fault_o <= 1'b0;
    end
    else if (bu_flush_i)                            // old stream is dead
    begin
      if_insn_o         <= `FETCH_NOP;
      if_bubble_o       <= 1'b1;
      if_illegal_o      <= 1'b0;
      if_access_fault_o <= 1'b0;
    end
    else if (!pd_stall_i)
    begin
      if_insn_o         <= valid_i ? insn_i : `FETCH_NOP;
      if_bubble_o       <= ~valid_i;                // incomplete head
      if_illegal_o      <= valid_i & illegal_i;
      if_access_fault_o <= valid_i & fault_i;
    end
  end

endmodule

// File: fetch_top.sv
// RV32 fetch with RVC; memory words return in order, two parcels each, imem_error_i per word
`timescale 1ns/1ps

module fetch_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  // instruction memory
  output fetch_pkg::addr_t  imem_adr_o,
  output logic              imem_req_o,
  output logic              imem_flush_o,
  input  logic              imem_ack_i,
  input  fetch_pkg::instr_t imem_parcel_i,
  input  logic        [1:0] imem_parcel_valid_i,
  input  logic              imem_error_i,
  // redirect and stall
  input  logic              bu_flush_i,
  input  fetch_pkg::addr_t  bu_nxt_pc_i,
  input  logic              pd_stall_i,
  // to decode
  output fetch_pkg::addr_t  if_pc_o,
  output fetch_pkg::instr_t if_insn_o,
  output logic              if_bubble_o,
  output logic              if_illegal_o,
  output logic              if_access_fault_o
);

  logic              almost_full;
  fetch_pkg::instr_t dec_insn;
  logic              dec_valid;
  logic              dec_rvc;
  logic              dec_illegal;
  logic              dec_fault;

  parcel_bus_if bus ();   // queue head to expander

  fetch_addr_gen u_addr_gen (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .imem_ack_i    ( imem_ack_i   ),
    .bu_flush_i    ( bu_flush_i   ),
    .bu_nxt_pc_i   ( bu_nxt_pc_i  ),
    .almost_full_i ( almost_full  ),
    .imem_adr_o    ( imem_adr_o   ),
    .imem_req_o    ( imem_req_o   ),
    .imem_flush_o  ( imem_flush_o )
  );

  parcel_queue u_queue (
    .clk_i         ( clk_i               ),
    .rst_ni        ( rst_ni              ),
    .flush_i       ( imem_flush_o        ),   // same strobe as the memory side
    .wr_parcels_i  ( imem_parcel_i       ),
    .wr_valid_i    ( imem_parcel_valid_i ),
    .wr_error_i    ( imem_error_i        ),
    .bus           ( bus.queue           ),
    .almost_full_o ( almost_full         )
  );

  rvc_expander u_expander (
    .bus       ( bus.expander ),
    .stall_i   ( pd_stall_i   ),
    .insn_o    ( dec_insn     ),
    .valid_o   ( dec_valid    ),
    .is_rvc_o  ( dec_rvc      ),
    .illegal_o ( dec_illegal  ),
    .fault_o   ( dec_fault    )
  );

  fetch_out_stage u_out (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .bu_flush_i        ( bu_flush_i        ),
    .bu_nxt_pc_i       ( bu_nxt_pc_i       ),
    .pd_stall_i        ( pd_stall_i        ),
    .valid_i           ( dec_valid         ),
    .is_rvc_i          ( dec_rvc           ),
    .illegal_i         ( dec_illegal       ),
    .fault_i           ( dec_fault         ),
    .insn_i            ( dec_insn          ),
    .if_pc_o           ( if_pc_o           ),
    .if_insn_o         ( if_insn_o         ),
    .if_bubble_o       ( if_bubble_o       ),
    .if_illegal_o      ( if_illegal_o      ),
    .if_access_fault_o ( if_access_fault_o )
  );

endmodule

// File: tb_fetch_top.sv
// self-checking fetch testbench; linear program from 0x200 with one redirect, expects in-order memory
`timescale 1ns/1ps
`include "fetch_params.svh"

module tb_fetch_top;

  localparam int PROG_HALVES = 160;                 // generated program, in parcels
  localparam int MEM_HALVES  = 200;                 // program plus nop pad
  localparam int END_HALF    = 170;                 // run ends once pc gets here
  localparam int FAULT_WORD  = 10;                  // word returned with access error
  localparam int TIMEOUT_CYC = PROG_HALVES * 8 + 200;
  localparam logic [31:0] BASE = `FETCH_PC_INIT;

  // compressed table: six legal, then 0x0000 and c.and as illegal
  localparam logic [15:0] RVC_ENC [8] = '{16'h428D, 16'h147D, 16'h852E, 16'h952E,
                                          16'h4044, 16'hA021, 16'h0000, 16'h8C65};
  localparam logic [31:0] RVC_EXP [8] = '{32'h0030_0293, 32'hFFF4_0413, 32'h00B0_0533,
                                          32'h00B5_0533, 32'h0044_2483, 32'h0080_006F,
                                          32'h0000_0000, 32'h0000_8C65};

  logic        clk_i, rst_ni;
  logic [31:0] imem_adr_o, imem_parcel_i, bu_nxt_pc_i, if_pc_o, if_insn_o;
  logic        imem_req_o, imem_flush_o, imem_ack_i, imem_error_i;
  logic [1:0]  imem_parcel_valid_i;
  logic        bu_flush_i, pd_stall_i;
  logic        if_bubble_o, if_illegal_o, if_access_fault_o;

  logic [15:0] mem_h     [MEM_HALVES];
  logic [31:0] exp_insn  [MEM_HALVES];               // shadow list, per parcel
  logic        exp_ill   [MEM_HALVES];
  logic        exp_fault [MEM_HALVES];
  int          exp_len   [MEM_HALVES];               // 0 where no insn starts

  logic [31:0] rsp_q [$];                            // accepted addresses in flight
  logic [31:0] exp_pc, flush_target, prev_pc, prev_insn;
  logic [2:0]  prev_flags;
  logic        s_req, s_ack, s_flush, prev_stall, prev_flush, flush_sent, done;
  logic [31:0] s_adr;
  int          errors, checks, cycle, faults_seen;

  fetch_top UUT (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;                      // 100 ns period
  end

  ////////////////////////////////////////
  // check helper
  task automatic compare(string name, logic [31:0] expv, logic [31:0] actv);
    checks++;
    assert (expv === actv)
    else
    begin
      errors++;
      $display("ERROR %s: expected %h actual %h", name, expv, actv);
    end
  endtask

  task automatic put_word(int h, logic [31:0] w, logic [31:0] e);
    mem_h[h]     = w[15:0];
    mem_h[h+1]   = w[31:16];
    exp_insn[h]  = e;
    exp_ill[h]   = 1'b0;
    exp_len[h]   = 4;
  endtask

  ////////////////////////////////////////
  // program and shadow list
  task automatic build_program();
    int h;
    int k;
    bit wfi_done;
    h = 0;
    wfi_done = 0;
    for (int i = 0; i < MEM_HALVES; i++)
    begin
      mem_h[i]   = 16'h0000;
      exp_len[i] = 0;
    end
    while (h < PROG_HALVES)
    begin
      k = $urandom_range(0, 9);
      if (!wfi_done && h >= 30)
      begin
        put_word(h, `FETCH_WFI, `FETCH_NOP);        // wfi shows up as nop
        wfi_done = 1;
        h += 2;
      end
      else if (k < 4)
      begin
        put_word(h, {7'b0, 5'($urandom), 5'($urandom), 3'($urandom), 5'($urandom),
                     7'b011_0011}, 32'h0);
        exp_insn[h] = {mem_h[h+1], mem_h[h]};       // r-type passes unchanged
        h += 2;
      end
      else
      begin
        k = $urandom_range(0, 7);
        mem_h[h]    = RVC_ENC[k];
        exp_insn[h] = RVC_EXP[k];
        exp_ill[h]  = k >= 6;
        exp_len[h]  = 2;
        h += 1;
      end
    end
    while (h + 1 < MEM_HALVES)
    begin
      put_word(h, `FETCH_NOP, `FETCH_NOP);          // pad for fetch-ahead
      h += 2;
    end
    for (int i = 0; i < MEM_HALVES; i++)            // fault if any parcel in the bad word
      exp_fault[i] = (exp_len[i] != 0) && ((i >> 1) == FAULT_WORD ||
                     (exp_len[i] == 4 && ((i + 1) >> 1) == FAULT_WORD));
    flush_target = '0;
    for (int i = PROG_HALVES - 1; i >= 100; i--)    // odd-halfword start, lowest wins
      if (exp_len[i] != 0 && i[0])
        flush_target = BASE + 32'(2 * i);
  endtask

  ////////////////////////////////////////
  // memory model, sampled mid-cycle
  always @(negedge clk_i)
  begin
    s_req   <= imem_req_o;
    s_ack   <= imem_ack_i;
    s_adr   <= imem_adr_o;
    s_flush <= imem_flush_o;
  end

  always @(posedge clk_i)
  begin
    int wi;
    bit sent;                                       // word put on the bus at this edge
    sent = 1'b0;
    if (rst_ni && s_flush)
    begin
      rsp_q.delete();                               // words in flight die
      imem_parcel_valid_i <= 2'b00;
    end
    else if (rst_ni)
    begin
      if (s_req && s_ack)
        rsp_q.push_back(s_adr);
      if (rsp_q.size() > 0 && $urandom_range(0, 2) != 0)
      begin
        wi = int'((rsp_q[0] - BASE) >> 2);
        imem_parcel_i       <= (wi < MEM_HALVES / 2) ? {mem_h[2*wi+1], mem_h[2*wi]}
                                                     : `FETCH_NOP;
        imem_parcel_valid_i <= rsp_q[0][1] ? 2'b10 : 2'b11;   // odd target, upper only
        imem_error_i        <= wi == FAULT_WORD;
        void'(rsp_q.pop_front());
        sent = 1'b1;
      end
      else
        imem_parcel_valid_i <= 2'b00;
    end
    // the word on the bus is not in the queue yet
    imem_ack_i <= ($urandom_range(0, 3) != 0) && (rsp_q.size() + int'(sent)) < 3;
  end

  ////////////////////////////////////////
  // stall and redirect stimulus
  always @(posedge clk_i)
    if (rst_ni)
    begin
      cycle <= cycle + 1;
      pd_stall_i <= (cycle >= 60 && cycle < 90) || ($urandom_range(0, 4) == 0);
      if (!flush_sent && exp_pc >= BASE + 32'd120)
      begin
        bu_flush_i  <= 1'b1;                        // one-cycle strobe
        bu_nxt_pc_i <= flush_target;
        flush_sent  <= 1'b1;
      end
      else
        bu_flush_i <= 1'b0;
    end

  ////////////////////////////////////////
  // output checks
  always @(negedge clk_i)
  begin
    int idx;
    if (rst_ni && !done)
    begin
      if (cycle == 0)                               // straight out of reset
      begin
        compare("reset_bubble", 1, if_bubble_o);
        compare("reset_pc", BASE, if_pc_o);
        compare("reset_flush", 0, imem_flush_o);
      end
      if (prev_stall && !prev_flush)                // outputs frozen
      begin
        compare("stall_pc", prev_pc, if_pc_o);
        compare("stall_insn", prev_insn, if_insn_o);
        compare("stall_flags", prev_flags,
                {if_bubble_o, if_illegal_o, if_access_fault_o});
      end
      else if (!if_bubble_o)
      begin
        compare("pc_order", exp_pc, if_pc_o);
        idx = int'((if_pc_o - BASE) >> 1);
        if (idx >= 0 && idx < MEM_HALVES && exp_len[idx] != 0)
        begin
          compare("insn", exp_insn[idx], if_insn_o);
          compare("illegal", exp_ill[idx], if_illegal_o);
          compare("access_fault", exp_fault[idx], if_access_fault_o);
          faults_seen += if_access_fault_o;
          exp_pc = if_pc_o + 32'(exp_len[idx]);
        end
        else
        begin
          errors++;
          $display("output pc %h is not the start of any program instruction", if_pc_o);
        end
      end
      if (cycle == 89)
        compare("req_backpressure", 0, imem_req_o);   // queue full under long stall
      if (bu_flush_i)
      begin
        compare("flush_same_cycle", 1, imem_flush_o);
        exp_pc = bu_nxt_pc_i;
      end
      if (exp_pc >= BASE + 32'(2 * END_HALF))
        done = 1'b1;
    end
    prev_stall = pd_stall_i;
    prev_flush = bu_flush_i;
    prev_pc    = if_pc_o;
    prev_insn  = if_insn_o;
    prev_flags = {if_bubble_o, if_illegal_o, if_access_fault_o};
  end

  ////////////////////////////////////////
  // watchdog
  initial
  begin
    repeat (TIMEOUT_CYC + 10) @(posedge clk_i);
    $display("timeout: fetch did not reach the end of the program, %0d errors", errors);
    $display("Done: errors found");
    $finish;
  end

  initial
  begin
    void'($urandom(95074));
    rst_ni = 1'b0;
    imem_ack_i = 1'b0;
    imem_parcel_i = '0;
    imem_parcel_valid_i = 2'b00;
    imem_error_i = 1'b0;
    bu_flush_i = 1'b0;
    bu_nxt_pc_i = '0;
    pd_stall_i = 1'b0;
    {errors, checks, cycle, faults_seen} = '0;
    {prev_stall, prev_flush, flush_sent, done} = '0;
    exp_pc = BASE;
    build_program();
    if (flush_target == '0)
    begin
      errors++;
      $display("no odd-halfword redirect target found in the program");
    end
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    wait (done);
    @(posedge clk_i);
    if (faults_seen == 0)
    begin
      errors++;
      $display("the faulting word never reached the output with its fault flag");
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+.
fetch_pkg.sv
parcel_bus_if.sv
fetch_addr_gen.sv
parcel_queue.sv
rvc_expander.sv
fetch_out_stage.sv
fetch_top.sv
tb_fetch_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_fetch_top
FILELIST  ?= vlog.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Done: no errors" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
